//--- mips_pkg.sv
package mips_pkg;

	// ====================
	// Opcodes
	localparam logic [5:0] op_sp     = 6'h00;
	localparam logic [5:0] op_regimm = 6'h01;
	localparam logic [5:0] op_beq    = 6'h04;
	localparam logic [5:0] op_bne    = 6'h05;
	localparam logic [5:0] op_blez   = 6'h06;
	localparam logic [5:0] op_bgtz   = 6'h07;
	localparam logic [5:0] op_addi   = 6'h08;
	localparam logic [5:0] op_addiu  = 6'h09;
	localparam logic [5:0] op_slti   = 6'h0a;
	localparam logic [5:0] op_sltiu  = 6'h0b;
	localparam logic [5:0] op_andi   = 6'h0c;
	localparam logic [5:0] op_ori    = 6'h0d;
	localparam logic [5:0] op_xori   = 6'h0e;
	localparam logic [5:0] op_lui    = 6'h0f;

	// Regimm branches are told apart by rt
	localparam logic [4:0] rt_bltz = 5'h00;
	localparam logic [4:0] rt_bgez = 5'h01;

	// ====================
	// Funct codes for op_sp
	localparam logic [5:0] func_sll  = 6'h00;
	localparam logic [5:0] func_srl  = 6'h02;
	localparam logic [5:0] func_sra  = 6'h03;
	localparam logic [5:0] func_sllv = 6'h04;
	localparam logic [5:0] func_srlv = 6'h06;
	localparam logic [5:0] func_srav = 6'h07;
	localparam logic [5:0] func_add  = 6'h20;
	localparam logic [5:0] func_addu = 6'h21;
	localparam logic [5:0] func_sub  = 6'h22;
	localparam logic [5:0] func_subu = 6'h23;
	localparam logic [5:0] func_and  = 6'h24;
	localparam logic [5:0] func_or   = 6'h25;
	localparam logic [5:0] func_xor  = 6'h26;
	localparam logic [5:0] func_nor  = 6'h27;
	localparam logic [5:0] func_slt  = 6'h2a;
	localparam logic [5:0] func_sltu = 6'h2b;

	// ====================
	// Operation encodings
	typedef enum logic [4:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_and, alu_or, alu_xor, alu_nor,
		alu_sll, alu_srl, alu_sra,
		alu_sllv, alu_srlv, alu_srav,
		alu_lui
	} alu_op_e;

	typedef enum logic [2:0] {
		cmp_none, cmp_eq, cmp_ne, cmp_gez, cmp_gtz, cmp_lez, cmp_ltz
	} cmp_op_e;

	typedef enum logic {
		ext_signed, ext_unsigned
	} ext_op_e;

	// ====================
	// Stage payloads
	typedef struct packed {
		alu_op_e    alu_op;
		cmp_op_e    cmp_op;
		ext_op_e    ext_op;
		logic       alu_b_imm;
		logic       reg_wr;
		logic [4:0] dest;
		logic       branch;
	} ctrl_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] opnd_a;
		logic [31:0] opnd_b;
		logic [4:0]  shamt;
		logic [31:0] br_target;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic        reg_wr;
		logic [4:0]  dest;
		logic [31:0] result;
		logic        br_valid;
		logic        br_taken;
		logic [31:0] br_target;
	} ex_wb_t;

	// Result still in execute, fed back to decode
	typedef struct packed {
		logic        valid;
		logic [4:0]  dest;
		logic [31:0] data;
	} fwd_t;

endpackage

//--- mips_ctrl.sv
module mips_ctrl (
	input  logic [31:0]     instr,
	output mips_pkg::ctrl_t ctrl
);

	logic [5:0] op;
	logic [5:0] func;
	logic [4:0] rt;
	logic [4:0] rd;

	assign op   = instr[31:26];
	assign func = instr[5:0];
	assign rt   = instr[20:16];
	assign rd   = instr[15:11];

	wire sp = (op == mips_pkg::op_sp);

	// ====================
	// I-type and branches
	wire addi  = (op == mips_pkg::op_addi);
	wire addiu = (op == mips_pkg::op_addiu);
	wire andi  = (op == mips_pkg::op_andi);
	wire ori   = (op == mips_pkg::op_ori);
	wire xori  = (op == mips_pkg::op_xori);
	wire slti  = (op == mips_pkg::op_slti);
	wire sltiu = (op == mips_pkg::op_sltiu);
	wire lui   = (op == mips_pkg::op_lui);
	wire beq   = (op == mips_pkg::op_beq);
	wire bne   = (op == mips_pkg::op_bne);
	wire blez  = (op == mips_pkg::op_blez);
	wire bgtz  = (op == mips_pkg::op_bgtz);
	wire bgez  = (op == mips_pkg::op_regimm) && (rt == mips_pkg::rt_bgez);
	wire bltz  = (op == mips_pkg::op_regimm) && (rt == mips_pkg::rt_bltz);

	// ====================
	// R-type
	wire add   = sp && (func == mips_pkg::func_add);
	wire addu  = sp && (func == mips_pkg::func_addu);
	wire sub   = sp && (func == mips_pkg::func_sub);
	wire subu  = sp && (func == mips_pkg::func_subu);
	wire f_and = sp && (func == mips_pkg::func_and);
	wire f_or  = sp && (func == mips_pkg::func_or);
	wire f_xor = sp && (func == mips_pkg::func_xor);
	wire f_nor = sp && (func == mips_pkg::func_nor);
	wire slt   = sp && (func == mips_pkg::func_slt);
	wire sltu  = sp && (func == mips_pkg::func_sltu);
	wire sll   = sp && (func == mips_pkg::func_sll);
	wire srl   = sp && (func == mips_pkg::func_srl);
	wire sra   = sp && (func == mips_pkg::func_sra);
	wire sllv  = sp && (func == mips_pkg::func_sllv);
	wire srlv  = sp && (func == mips_pkg::func_srlv);
	wire srav  = sp && (func == mips_pkg::func_srav);

	// Instruction classes
	wire calr   = add | addu | sub | subu | f_and | f_or | f_xor | f_nor |
	              slt | sltu | sll | srl | sra | sllv | srlv | srav;
	wire cali   = addi | addiu | andi | ori | xori | slti | sltiu;
	wire branch = beq | bne | blez | bgtz | bgez | bltz;

	logic [4:0] dest;

	// rd for R-type, rt for immediates
	assign dest = calr ? rd : ((cali | lui) ? rt : 5'd0);

	always_comb begin
		ctrl.alu_op = (sub | subu)   ? mips_pkg::alu_sub  :
		              (slt | slti)   ? mips_pkg::alu_slt  :
		              (sltu | sltiu) ? mips_pkg::alu_sltu :
		              (f_and | andi) ? mips_pkg::alu_and  :
		              (f_or | ori)   ? mips_pkg::alu_or   :
		              (f_xor | xori) ? mips_pkg::alu_xor  :
		              f_nor          ? mips_pkg::alu_nor  :
		              sll            ? mips_pkg::alu_sll  :
		              srl            ? mips_pkg::alu_srl  :
		              sra            ? mips_pkg::alu_sra  :
		              sllv           ? mips_pkg::alu_sllv :
		              srlv           ? mips_pkg::alu_srlv :
		              srav           ? mips_pkg::alu_srav :
		              lui            ? mips_pkg::alu_lui  : mips_pkg::alu_add;

		ctrl.cmp_op = beq  ? mips_pkg::cmp_eq  :
		              bne  ? mips_pkg::cmp_ne  :
		              bgez ? mips_pkg::cmp_gez :
		              bgtz ? mips_pkg::cmp_gtz :
		              blez ? mips_pkg::cmp_lez :
		              bltz ? mips_pkg::cmp_ltz : mips_pkg::cmp_none;

		// Logic immediates are zero-extended
		ctrl.ext_op    = (andi | ori | xori) ? mips_pkg::ext_unsigned : mips_pkg::ext_signed;
		ctrl.alu_b_imm = cali | lui;
		ctrl.reg_wr    = (calr | cali | lui) && (dest != 5'd0);
		ctrl.dest      = dest;
		ctrl.branch    = branch;
	end

endmodule

//--- mips_regfile.sv
module mips_regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [0:31];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// r0 always reads zero
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

//--- mips_decode_stage.sv
module mips_decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic [31:0]        in_instr,
	input  logic [31:0]        in_pc,
	input  mips_pkg::fwd_t     fwd,
	input  mips_pkg::ex_wb_t   wb,
	output mips_pkg::id_ex_t   id_ex
);

	mips_pkg::ctrl_t  ctrl;
	mips_pkg::id_ex_t id_ex_d;
	logic [4:0]       rs;
	logic [4:0]       rt;
	logic [31:0]      rf_a;
	logic [31:0]      rf_b;
	logic [31:0]      imm_ext;
	logic [31:0]      br_offset;

	assign rs = in_instr[25:21];
	assign rt = in_instr[20:16];

	mips_ctrl u_ctrl (
		.instr (in_instr),
		.ctrl  (ctrl)
	);

	mips_regfile u_regfile (
		.clk   (clk),
		.rst_n (rst_n),
		.ra1   (rs),
		.ra2   (rt),
		.we    (wb.valid & wb.reg_wr),
		.wa    (wb.dest),
		.wd    (wb.result),
		.rd1   (rf_a),
		.rd2   (rf_b)
	);

	// Newest value wins: execute, then writeback, then register file
	function automatic logic [31:0] fwd_sel(input logic [4:0] addr,
		input logic [31:0] rf_data, input mips_pkg::fwd_t ex_src,
		input mips_pkg::ex_wb_t wb_src);
		if (ex_src.valid && (ex_src.dest == addr)) begin
			return ex_src.data;
		end else if (wb_src.valid && wb_src.reg_wr && (wb_src.dest == addr)) begin
			return wb_src.result;
		end
		return rf_data;
	endfunction

	assign imm_ext   = (ctrl.ext_op == mips_pkg::ext_signed) ?
	                   {{16{in_instr[15]}}, in_instr[15:0]} : {16'd0, in_instr[15:0]};
	assign br_offset = {{14{in_instr[15]}}, in_instr[15:0], 2'b00};

	always_comb begin
		id_ex_d.valid     = in_valid;
		id_ex_d.ctrl      = ctrl;
		id_ex_d.opnd_a    = fwd_sel(rs, rf_a, fwd, wb);
		id_ex_d.opnd_b    = ctrl.alu_b_imm ? imm_ext : fwd_sel(rt, rf_b, fwd, wb);
		id_ex_d.shamt     = in_instr[10:6];
		id_ex_d.br_target = in_pc + 32'd4 + br_offset;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex <= id_ex_d;
		end
	end

endmodule

//--- mips_execute_stage.sv
module mips_execute_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  mips_pkg::id_ex_t id_ex,
	output mips_pkg::fwd_t   fwd,
	output mips_pkg::ex_wb_t ex_wb
);

	logic [31:0]      a;
	logic [31:0]      b;
	logic [31:0]      alu_res;
	logic             br_taken;
	mips_pkg::ex_wb_t ex_wb_d;

	assign a = id_ex.opnd_a;
	assign b = id_ex.opnd_b;

	// ====================
	// ALU
	always_comb begin
		case (id_ex.ctrl.alu_op)
			mips_pkg::alu_add:  alu_res = a + b;
			mips_pkg::alu_sub:  alu_res = a - b;
			mips_pkg::alu_slt:  alu_res = {31'd0, $signed(a) < $signed(b)};
			mips_pkg::alu_sltu: alu_res = {31'd0, a < b};
			mips_pkg::alu_and:  alu_res = a & b;
			mips_pkg::alu_or:   alu_res = a | b;
			mips_pkg::alu_xor:  alu_res = a ^ b;
			mips_pkg::alu_nor:  alu_res = ~(a | b);
			// Shifts act on rt, by shamt or by rs[4:0]
			mips_pkg::alu_sll:  alu_res = b << id_ex.shamt;
			mips_pkg::alu_srl:  alu_res = b >> id_ex.shamt;
			mips_pkg::alu_sra:  alu_res = $signed(b) >>> id_ex.shamt;
			mips_pkg::alu_sllv: alu_res = b << a[4:0];
			mips_pkg::alu_srlv: alu_res = b >> a[4:0];
			mips_pkg::alu_srav: alu_res = $signed(b) >>> a[4:0];
			mips_pkg::alu_lui:  alu_res = {b[15:0], 16'd0};
			default:            alu_res = 32'd0;
		endcase
	end

	// ====================
	// Branch compare
	always_comb begin
		case (id_ex.ctrl.cmp_op)
			mips_pkg::cmp_eq:  br_taken = (a == b);
			mips_pkg::cmp_ne:  br_taken = (a != b);
			mips_pkg::cmp_gez: br_taken = !a[31];
			mips_pkg::cmp_gtz: br_taken = !a[31] && (a != 32'd0);
			mips_pkg::cmp_lez: br_taken = a[31] || (a == 32'd0);
			mips_pkg::cmp_ltz: br_taken = a[31];
			default:           br_taken = 1'b0;
		endcase
	end

	assign fwd = '{
		valid: id_ex.valid & id_ex.ctrl.reg_wr,
		dest:  id_ex.ctrl.dest,
		data:  alu_res
	};

	always_comb begin
		ex_wb_d.valid     = id_ex.valid;
		ex_wb_d.reg_wr    = id_ex.ctrl.reg_wr;
		ex_wb_d.dest      = id_ex.ctrl.dest;
		ex_wb_d.result    = alu_res;
		ex_wb_d.br_valid  = id_ex.valid & id_ex.ctrl.branch;
		ex_wb_d.br_taken  = br_taken;
		ex_wb_d.br_target = id_ex.br_target;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_wb.valid    <= 1'b0;
			ex_wb.br_valid <= 1'b0;
		end else begin
			ex_wb <= ex_wb_d;
		end
	end

endmodule

//--- mips_int_pipe.sv
module mips_int_pipe (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic [31:0] in_instr,
	input  logic [31:0] in_pc,
	output logic        wb_valid,
	output logic [4:0]  wb_dest,
	output logic [31:0] wb_data,
	output logic        br_valid,
	output logic        br_taken,
	output logic [31:0] br_target
);

	mips_pkg::fwd_t   fwd;
	mips_pkg::id_ex_t id_ex;
	mips_pkg::ex_wb_t ex_wb;

	mips_decode_stage u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.fwd      (fwd),
		.wb       (ex_wb),
		.id_ex    (id_ex)
	);

	mips_execute_stage u_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.id_ex (id_ex),
		.fwd   (fwd),
		.ex_wb (ex_wb)
	);

	// Writeback results
	assign wb_valid  = ex_wb.valid & ex_wb.reg_wr;
	assign wb_dest   = ex_wb.dest;
	assign wb_data   = ex_wb.result;
	assign br_valid  = ex_wb.br_valid;
	assign br_taken  = ex_wb.br_taken;
	assign br_target = ex_wb.br_target;

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held over three rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- mips_int_pipe_properties.sv
module mips_int_pipe_properties (
	input logic       clk,
	input logic       rst_n,
	input logic       wb_valid,
	input logic [4:0] wb_dest,
	input logic       br_valid
);

	// r0 is never reported as written
	wb_dest_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb_dest != 5'd0))
		else $error("wb_valid asserted with destination r0");

	// A branch writes no register
	wb_br_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && br_valid))
		else $error("wb_valid and br_valid asserted together");

	outputs_low_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!wb_valid && !br_valid))
		else $error("Output valid asserted while reset is active");

endmodule

bind mips_int_pipe mips_int_pipe_properties u_properties (
	.clk      (clk),
	.rst_n    (rst_n),
	.wb_valid (wb_valid),
	.wb_dest  (wb_dest),
	.br_valid (br_valid)
);

//--- mips_int_pipe_tb.sv
module mips_int_pipe_tb;

	typedef struct packed {
		logic        has_out;
		logic        is_br;
		logic [4:0]  dest;
		logic [31:0] data;
		logic        taken;
		logic [31:0] target;
		logic [31:0] issue;
	} exp_t;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [31:0] in_instr;
	logic [31:0] in_pc;
	logic        wb_valid;
	logic [4:0]  wb_dest;
	logic [31:0] wb_data;
	logic        br_valid;
	logic        br_taken;
	logic [31:0] br_target;

	logic [31:0] model_rf [0:31];
	logic [31:0] pc;
	exp_t        exp_q [$];
	int          cyc = 0;
	int          value_errs = 0;
	int          extra_errs = 0;
	int          n_random = 400;

	logic [5:0]  func_list [0:15] = '{
		mips_pkg::func_add, mips_pkg::func_addu, mips_pkg::func_sub, mips_pkg::func_subu,
		mips_pkg::func_and, mips_pkg::func_or, mips_pkg::func_xor, mips_pkg::func_nor,
		mips_pkg::func_slt, mips_pkg::func_sltu, mips_pkg::func_sll, mips_pkg::func_srl,
		mips_pkg::func_sra, mips_pkg::func_sllv, mips_pkg::func_srlv, mips_pkg::func_srav};
	logic [5:0]  i_ops [0:7] = '{
		mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
		mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
	// r2 all ones, r3 sign bit, r4 largest positive, r5 holds 31
	logic [4:0]  srcs [0:4] = '{5'd0, 5'd2, 5'd3, 5'd4, 5'd5};
	logic [4:0]  shamts [0:2] = '{5'd0, 5'd1, 5'd31};
	logic [15:0] imms [0:3] = '{16'h0000, 16'hffff, 16'h8000, 16'h7fff};
	logic [4:0]  br_rs [0:3] = '{5'd0, 5'd8, 5'd8, 5'd11};
	logic [4:0]  br_rt [0:3] = '{5'd0, 5'd9, 5'd11, 5'd0};

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mips_int_pipe u_mips_int_pipe (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_pc     (in_pc),
		.wb_valid  (wb_valid),
		.wb_dest   (wb_dest),
		.wb_data   (wb_data),
		.br_valid  (br_valid),
		.br_taken  (br_taken),
		.br_target (br_target)
	);

	function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {mips_pkg::op_sp, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] br_instr(input logic [2:0] k, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] off);
		case (k)
			3'd0: return i_type(mips_pkg::op_beq, rs, rt, off);
			3'd1: return i_type(mips_pkg::op_bne, rs, rt, off);
			3'd2: return i_type(mips_pkg::op_blez, rs, 5'd0, off);
			3'd3: return i_type(mips_pkg::op_bgtz, rs, 5'd0, off);
			3'd4: return i_type(mips_pkg::op_regimm, rs, mips_pkg::rt_bgez, off);
			default: return i_type(mips_pkg::op_regimm, rs, mips_pkg::rt_bltz, off);
		endcase
	endfunction

	// ====================
	// Architectural model, one instruction at a time in program order
	function automatic exp_t ref_exec(input logic [31:0] instr, input logic [31:0] ipc);
		exp_t        e;
		logic [5:0]  op;
		logic [4:0]  rt;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [31:0] r;
		logic [4:0]  d;
		logic        wr;
		logic        br;
		logic        taken;
		op    = instr[31:26];
		rt    = instr[20:16];
		sh    = instr[10:6];
		a     = model_rf[instr[25:21]];
		b     = model_rf[rt];
		simm  = {{16{instr[15]}}, instr[15:0]};
		zimm  = {16'd0, instr[15:0]};
		r     = 32'd0;
		d     = 5'd0;
		wr    = 1'b0;
		br    = 1'b0;
		taken = 1'b0;
		case (op)
			mips_pkg::op_sp: begin
				wr = 1'b1;
				d  = instr[15:11];
				case (instr[5:0])
					mips_pkg::func_add, mips_pkg::func_addu: r = a + b;
					mips_pkg::func_sub, mips_pkg::func_subu: r = a - b;
					mips_pkg::func_and:  r = a & b;
					mips_pkg::func_or:   r = a | b;
					mips_pkg::func_xor:  r = a ^ b;
					mips_pkg::func_nor:  r = ~(a | b);
					mips_pkg::func_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::func_sltu: r = (a < b) ? 32'd1 : 32'd0;
					mips_pkg::func_sll:  r = b << sh;
					mips_pkg::func_srl:  r = b >> sh;
					mips_pkg::func_sra:  r = $signed(b) >>> sh;
					mips_pkg::func_sllv: r = b << a[4:0];
					mips_pkg::func_srlv: r = b >> a[4:0];
					mips_pkg::func_srav: r = $signed(b) >>> a[4:0];
					default: wr = 1'b0;
				endcase
			end
			mips_pkg::op_addi, mips_pkg::op_addiu: r = a + simm;
			mips_pkg::op_slti:  r = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			mips_pkg::op_sltiu: r = (a < simm) ? 32'd1 : 32'd0;
			mips_pkg::op_andi:  r = a & zimm;
			mips_pkg::op_ori:   r = a | zimm;
			mips_pkg::op_xori:  r = a ^ zimm;
			mips_pkg::op_lui:   r = {instr[15:0], 16'd0};
			mips_pkg::op_beq:   {br, taken} = {1'b1, a == b};
			mips_pkg::op_bne:   {br, taken} = {1'b1, a != b};
			mips_pkg::op_blez:  {br, taken} = {1'b1, $signed(a) <= 32'sd0};
			mips_pkg::op_bgtz:  {br, taken} = {1'b1, $signed(a) > 32'sd0};
			mips_pkg::op_regimm: begin
				if (rt == mips_pkg::rt_bgez)
					{br, taken} = {1'b1, $signed(a) >= 32'sd0};
				else if (rt == mips_pkg::rt_bltz)
					{br, taken} = {1'b1, $signed(a) < 32'sd0};
			end
			default: r = 32'd0;
		endcase
		// Opcodes 0x08 to 0x0f are the immediate group
		if ((op >= mips_pkg::op_addi) && (op <= mips_pkg::op_lui)) begin
			wr = 1'b1;
			d  = rt;
		end
		if (wr && (d != 5'd0))
			model_rf[d] = r;
		e.has_out = (wr && (d != 5'd0)) || br;
		e.is_br   = br;
		e.dest    = d;
		e.data    = r;
		e.taken   = taken;
		e.target  = ipc + 32'd4 + {simm[29:0], 2'b00};
		e.issue   = 32'd0;
		return e;
	endfunction

	task automatic issue(input logic [31:0] instr);
		exp_t e;
		@(negedge clk);
		in_valid = 1'b1;
		in_instr = instr;
		in_pc    = pc;
		e = ref_exec(instr, pc);
		e.issue = cyc;
		if (e.has_out)
			exp_q.push_back(e);
		pc = pc + 32'd4;
	endtask

	task automatic bubble();
		@(negedge clk);
		in_valid = 1'b0;
		in_instr = $urandom;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		issue(i_type(mips_pkg::op_lui, 5'd0, rd, value[31:16]));
		issue(i_type(mips_pkg::op_ori, rd, rd, value[15:0]));
	endtask

	always @(posedge clk)
		cyc <= cyc + 1;

	// ====================
	// Output checker
	always @(negedge clk) begin
		exp_t e;
		if (rst_n && (wb_valid || br_valid)) begin
			if (exp_q.size() == 0) begin
				$display("Output at time %0t while no instruction was outstanding", $time);
				extra_errs++;
			end else begin
				e = exp_q.pop_front();
				assert (cyc == e.issue + 2) else begin
					$display("ERR %0t: issued at cycle %0d, result at cycle %0d",
						$time, e.issue, cyc);
					value_errs++;
				end
				if (!e.is_br) begin
					assert (wb_valid && !br_valid && wb_dest == e.dest && wb_data == e.data)
					else begin
						$display("ERR %0t: wb %0b r%0d=%h, expected r%0d=%h", $time,
							wb_valid, wb_dest, wb_data, e.dest, e.data);
						value_errs++;
					end
				end else begin
					assert (br_valid && !wb_valid && br_taken == e.taken &&
						br_target == e.target) else begin
						$display("ERR %0t: branch %0b taken=%0b target=%h, expected %0b %h",
							$time, br_valid, br_taken, br_target, e.taken, e.target);
						value_errs++;
					end
				end
			end
		end
	end

	initial begin
		int limit;
		// Reset, directed groups, random mix with bubbles and the drain, plus margin
		limit = 4 + 8 + 16 * 25 + 8 * 20 + 54 + 102 + 12 + 2 * n_random + 13 + 20;
		while (cyc < limit)
			@(posedge clk);
		$display("Timeout after %0d cycles, %0d results never arrived", cyc, exp_q.size());
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int         n;
		int         missing;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		void'($urandom(32'hc87f409a));
		in_valid = 1'b0;
		in_instr = 32'd0;
		in_pc    = 32'd0;
		pc       = 32'h0040_0000;
		for (int i = 0; i < 32; i++)
			model_rf[i] = 32'd0;
		@(posedge rst_n);

		load_const(5'd2, 32'hffff_ffff);
		load_const(5'd3, 32'h8000_0000);
		load_const(5'd4, 32'h7fff_ffff);
		load_const(5'd5, 32'd31);
		for (int f = 0; f < 16; f++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					issue(r_type(func_list[f], srcs[i], srcs[j], 5'(10 + j), shamts[(i + j) % 3]));
		for (int o = 0; o < 8; o++)
			for (int i = 0; i < 5; i++)
				for (int k = 0; k < 4; k++)
					issue(i_type(i_ops[o], srcs[i], 5'(16 + k), imms[k]));

		// Dependent chains on r6 at distance 1, 2 and 3
		for (int d = 1; d <= 3; d++) begin
			load_const(5'd6, 32'h1234_5678);
			for (int s = 0; s < 8; s++) begin
				repeat (d - 1) issue(i_type(mips_pkg::op_addiu, 5'd0, 5'd20, 16'(s)));
				case (s % 4)
					0: issue(r_type(mips_pkg::func_addu, 5'd6, 5'd4, 5'd6, 5'd0));
					1: issue(r_type(mips_pkg::func_subu, 5'd2, 5'd6, 5'd6, 5'd0));
					2: issue(i_type(mips_pkg::op_xori, 5'd6, 5'd6, 16'h5a5a));
					default: issue(r_type(mips_pkg::func_sllv, 5'd6, 5'd6, 5'd6, 5'd0));
				endcase
			end
		end

		load_const(5'd8, 32'd5);
		load_const(5'd9, 32'd5);
		load_const(5'd11, 32'hffff_fffd);
		pc = 32'h0000_0010;
		for (int k = 0; k < 6; k++)
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					issue(br_instr(3'(k), br_rs[i], br_rt[i], imms[j]));

		// Writes to r0, then encodings outside the core
		issue(i_type(mips_pkg::op_addiu, 5'd2, 5'd0, 16'h0005));
		issue(r_type(mips_pkg::func_addu, 5'd2, 5'd3, 5'd0, 5'd0));
		issue(i_type(mips_pkg::op_lui, 5'd0, 5'd0, 16'hffff));
		issue(r_type(mips_pkg::func_sll, 5'd0, 5'd2, 5'd0, 5'd3));
		issue(r_type(mips_pkg::func_addu, 5'd0, 5'd0, 5'd12, 5'd0));
		issue(r_type(mips_pkg::func_or, 5'd0, 5'd2, 5'd13, 5'd0));
		issue(i_type(6'h23, 5'd2, 5'd14, 16'h0000));
		issue(i_type(6'h2b, 5'd2, 5'd14, 16'h0004));
		issue({6'h02, 26'h000_0123});
		issue(r_type(6'h18, 5'd2, 5'd3, 5'd0, 5'd0));
		issue(i_type(mips_pkg::op_regimm, 5'd2, 5'h10, 16'h0004));
		issue(r_type(mips_pkg::func_addu, 5'd14, 5'd0, 5'd15, 5'd0));

		// ====================
		// Random mix on r0 to r7 for dense dependencies
		pc = 32'hbfc0_0000;
		for (int k = 0; k < n_random; k++) begin
			rs = 5'($urandom_range(7));
			rt = 5'($urandom_range(7));
			rd = 5'($urandom_range(7));
			if ($urandom_range(3) == 0)
				bubble();
			case ($urandom_range(9))
				0, 1, 2, 3: issue(r_type(func_list[4'($urandom_range(15))], rs, rt, rd, 5'($urandom)));
				4, 5, 6: issue(i_type(i_ops[3'($urandom_range(7))], rs, rt, 16'($urandom)));
				7, 8: issue(br_instr(3'($urandom_range(5)), rs, rt, 16'($urandom)));
				default: issue($urandom);
			endcase
		end

		n = 0;
		while ((exp_q.size() != 0) && (n < 10)) begin
			bubble();
			n++;
		end
		repeat (3) bubble();
		missing = exp_q.size();
		if (missing != 0)
			$display("%0d expected results never appeared at the outputs", missing);
		$display("Errors: %0d wrong values, %0d unexpected outputs, %0d missing outputs",
			value_errs, extra_errs, missing);
		if ((value_errs + extra_errs + missing) == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- all.f
mips_pkg.sv
mips_ctrl.sv
mips_regfile.sv
mips_decode_stage.sv
mips_execute_stage.sv
mips_int_pipe.sv
tb_clock_gen.sv
mips_int_pipe_properties.sv
mips_int_pipe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for the fail message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module mips_int_pipe_tb -o sim_mips
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mips > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
